// ==== include/cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// lanes that can issue in one cycle.
`define ISSUE_NUM 2

// stages between EX and WB, the last one registers the product.
`define MUL_PIPE_DEPTH 2

// queue entries, which is also the credit count the sender starts with.
`define FETCH_QUEUE_DEPTH 8

`define REG_NUM 32

`endif

// ==== hdl/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	typedef logic [4:0]  reg_addr_t;
	typedef logic [31:0] uint32_t;

	localparam logic [5:0] OPC_SPECIAL = 6'h00;
	localparam logic [5:0] OPC_ADDI    = 6'h08;  // immediate is sign-extended.
	localparam logic [5:0] OPC_ORI     = 6'h0d;  // immediate is zero-extended.

	localparam logic [5:0] FUNCT_ADD = 6'h20;
	localparam logic [5:0] FUNCT_SUB = 6'h22;
	localparam logic [5:0] FUNCT_AND = 6'h24;
	localparam logic [5:0] FUNCT_OR  = 6'h25;
	localparam logic [5:0] FUNCT_XOR = 6'h26;
	localparam logic [5:0] FUNCT_MUL = 6'h18;

	typedef enum logic [2:0] {
		OP_NOP,
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_MUL
	} alu_op_e;

	typedef struct packed {
		logic [5:0] opcode;
		reg_addr_t  rs1;
		reg_addr_t  rs2;
		reg_addr_t  rd;
		logic [4:0] unused;
		logic [5:0] funct;
	} r_fmt_t;

	typedef struct packed {
		logic [5:0]  opcode;
		reg_addr_t   rs1;
		reg_addr_t   rd;
		logic [15:0] imm;
	} i_fmt_t;

	// the same 32 bits, read as register or immediate format.
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
	} instr_word_u;

	typedef struct packed {
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
		alu_op_e   op;
		uint32_t   imm;
		logic      uses_imm;
		logic      is_mul;
	} decoded_instr_t;

	typedef struct packed {
		logic           valid;
		instr_word_u    instr;
		decoded_instr_t decoded;
	} fetch_entry_t;

	typedef struct packed {
		logic           valid;
		decoded_instr_t decoded;
		uint32_t        reg1;
		uint32_t        reg2;
	} pipeline_decode_t;

	typedef struct packed {
		logic           valid;
		decoded_instr_t decoded;
		uint32_t        result;
	} pipeline_exec_t;

	typedef struct packed {
		logic      valid;
		reg_addr_t rd;
		uint32_t   wdata;
	} pipeline_memwb_t;

endpackage

`default_nettype wire

// ==== hdl/bypass_if.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

interface bypass_if;
	import cpu_pkg::*;

	pipeline_exec_t  [`ISSUE_NUM-1:0]                      pipeline_exec;
	pipeline_exec_t  [`MUL_PIPE_DEPTH-1:0][`ISSUE_NUM-1:0] pipeline_stage;  // index 0 is stage 1.
	pipeline_memwb_t [`ISSUE_NUM-1:0]                      pipeline_wb;
	reg_addr_t       [`ISSUE_NUM*2-1:0]                    reg_raddr;
	uint32_t         [`ISSUE_NUM*2-1:0]                    reg_rdata;

	modport producer(output pipeline_exec, pipeline_stage, pipeline_wb, reg_rdata,
		input reg_raddr);
	modport consumer(input pipeline_exec, pipeline_stage, pipeline_wb, reg_rdata,
		output reg_raddr);

endinterface

`default_nettype wire

// ==== hdl/instr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decoder(
	input  cpu_pkg::instr_word_u    instr,
	output cpu_pkg::decoded_instr_t decoded_instr
);
	import cpu_pkg::*;

	logic known;

	always_comb begin
		decoded_instr = '0;
		known = 1'b1;
		case (instr.r_fmt.opcode)
			OPC_SPECIAL: begin
				decoded_instr.rs1 = instr.r_fmt.rs1;
				decoded_instr.rs2 = instr.r_fmt.rs2;
				decoded_instr.rd  = instr.r_fmt.rd;
				case (instr.r_fmt.funct)
					FUNCT_ADD: decoded_instr.op = OP_ADD;
					FUNCT_SUB: decoded_instr.op = OP_SUB;
					FUNCT_AND: decoded_instr.op = OP_AND;
					FUNCT_OR:  decoded_instr.op = OP_OR;
					FUNCT_XOR: decoded_instr.op = OP_XOR;
					FUNCT_MUL: decoded_instr.op = OP_MUL;
					default:   known = 1'b0;
				endcase
			end
			OPC_ADDI: begin
				decoded_instr.rs1 = instr.i_fmt.rs1;
				decoded_instr.rd  = instr.i_fmt.rd;
				decoded_instr.op  = OP_ADD;
				decoded_instr.imm = {{16{instr.i_fmt.imm[15]}}, instr.i_fmt.imm};
				decoded_instr.uses_imm = 1'b1;
			end
			OPC_ORI: begin
				decoded_instr.rs1 = instr.i_fmt.rs1;
				decoded_instr.rd  = instr.i_fmt.rd;
				decoded_instr.op  = OP_OR;
				decoded_instr.imm = {16'h0000, instr.i_fmt.imm};
				decoded_instr.uses_imm = 1'b1;
			end
			default: known = 1'b0;
		endcase
		decoded_instr.is_mul = (decoded_instr.op == OP_MUL);
		if (!known)
			decoded_instr = '0;  // a NOP reads nothing and writes r0.
	end

endmodule

`default_nettype wire

// ==== hdl/fetch_queue.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module fetch_queue(
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic                                   instr_valid,
	input  cpu_pkg::uint32_t                       instr,
	output cpu_pkg::fetch_entry_t [`ISSUE_NUM-1:0] fetch_entry,
	input  logic [$clog2(`ISSUE_NUM+1)-1:0]        issue_num,
	output logic [$clog2(`ISSUE_NUM+1)-1:0]        credit_return
);
	import cpu_pkg::*;

	localparam int PTR_W = $clog2(`FETCH_QUEUE_DEPTH);  // pointers wrap, so depth is a power of two.
	localparam int CNT_W = $clog2(`FETCH_QUEUE_DEPTH + 1);

	instr_word_u      mem_instr   [`FETCH_QUEUE_DEPTH];
	decoded_instr_t   mem_decoded [`FETCH_QUEUE_DEPTH];
	decoded_instr_t   push_decoded;
	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] tail;
	logic [CNT_W-1:0] count;

	instr_decoder i_decoder(
		.instr         ( instr        ),
		.decoded_instr ( push_decoded )
	);

	always_ff @(posedge clk) begin
		if (instr_valid) begin
			mem_instr[tail]   <= instr;
			mem_decoded[tail] <= push_decoded;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			head          <= '0;
			tail          <= '0;
			count         <= '0;
			credit_return <= '0;
		end else begin
			head          <= head + PTR_W'(issue_num);
			tail          <= tail + PTR_W'(instr_valid);
			count         <= count + CNT_W'(instr_valid) - CNT_W'(issue_num);
			credit_return <= issue_num;  // one credit back per popped entry.
		end
	end

	for (genvar i = 0; i < `ISSUE_NUM; i++) begin : gen_head
		assign fetch_entry[i].valid   = (count > CNT_W'(i));
		assign fetch_entry[i].instr   = mem_instr[head + PTR_W'(i)];
		assign fetch_entry[i].decoded = mem_decoded[head + PTR_W'(i)];
	end

	// the sender only pushes while it holds a credit.
	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		instr_valid |-> count < CNT_W'(`FETCH_QUEUE_DEPTH));

	a_pop_within_count: assert property (@(posedge clk) disable iff (!rst_n)
		CNT_W'(issue_num) <= count);

endmodule

`default_nettype wire

// ==== hdl/register_forward.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module register_forward(
	input  cpu_pkg::decoded_instr_t decoded_instr,
	bypass_if.consumer              bypass,
	input  cpu_pkg::uint32_t        reg1_i,
	input  cpu_pkg::uint32_t        reg2_i,
	output cpu_pkg::uint32_t        reg1_o,
	output cpu_pkg::uint32_t        reg2_o
);
	import cpu_pkg::*;

	reg_addr_t src [2];
	uint32_t   val [2];

	assign src[0] = decoded_instr.rs1;
	assign src[1] = decoded_instr.rs2;

	// oldest producer first, so the newest match is the one that stays.
	always_comb begin
		for (int s = 0; s < 2; s++) begin
			val[s] = (s == 0) ? reg1_i : reg2_i;
			for (int i = 0; i < `ISSUE_NUM; i++)
				if (bypass.pipeline_wb[i].valid && bypass.pipeline_wb[i].rd == src[s])
					val[s] = bypass.pipeline_wb[i].wdata;
			for (int k = `MUL_PIPE_DEPTH - 1; k >= 0; k--)
				for (int i = 0; i < `ISSUE_NUM; i++)
					if (bypass.pipeline_stage[k][i].valid &&
						!bypass.pipeline_stage[k][i].decoded.is_mul &&
						bypass.pipeline_stage[k][i].decoded.rd == src[s])
						val[s] = bypass.pipeline_stage[k][i].result;
			for (int i = 0; i < `ISSUE_NUM; i++)
				if (bypass.pipeline_exec[i].valid && !bypass.pipeline_exec[i].decoded.is_mul &&
					bypass.pipeline_exec[i].decoded.rd == src[s])
					val[s] = bypass.pipeline_exec[i].result;
			if (src[s] == '0)
				val[s] = '0;  // r0 reads zero whatever sits in the pipe.
		end
	end

	assign reg1_o = val[0];
	assign reg2_o = val[1];

endmodule

`default_nettype wire

// ==== hdl/instr_issue.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module instr_issue(
	input  cpu_pkg::fetch_entry_t   [`ISSUE_NUM-1:0]                      fetch_entry,
	input  cpu_pkg::decoded_instr_t [`ISSUE_NUM-1:0]                      id_decoded,
	input  cpu_pkg::decoded_instr_t [`ISSUE_NUM-1:0]                      ex_decoded,
	input  cpu_pkg::decoded_instr_t [`MUL_PIPE_DEPTH-1:0][`ISSUE_NUM-1:0] stage_decoded,
	output logic [$clog2(`ISSUE_NUM+1)-1:0]                               issue_num,
	output logic                                                          stall_req
);
	import cpu_pkg::*;

	logic [`ISSUE_NUM-1:0] blocked;
	logic [`ISSUE_NUM-1:0] can_issue;

	function automatic logic reads_rd(decoded_instr_t consumer, reg_addr_t rd);
		return (rd != '0) && (consumer.rs1 == rd || consumer.rs2 == rd);
	endfunction

	// a MUL result exists only in WB, and an older lane of the same pair forwards nothing.
	always_comb begin
		for (int i = 0; i < `ISSUE_NUM; i++) begin
			blocked[i] = 1'b0;
			for (int l = 0; l < `ISSUE_NUM; l++) begin
				if (ex_decoded[l].is_mul && reads_rd(id_decoded[i], ex_decoded[l].rd))
					blocked[i] = 1'b1;
				for (int k = 0; k < `MUL_PIPE_DEPTH; k++)
					if (stage_decoded[k][l].is_mul &&
						reads_rd(id_decoded[i], stage_decoded[k][l].rd))
						blocked[i] = 1'b1;
			end
			for (int j = 0; j < i; j++)
				if (reads_rd(id_decoded[i], id_decoded[j].rd))
					blocked[i] = 1'b1;
		end
	end

	always_comb begin
		logic in_order;
		in_order = 1'b1;
		issue_num = '0;
		stall_req = 1'b0;
		for (int i = 0; i < `ISSUE_NUM; i++) begin
			can_issue[i] = in_order && fetch_entry[i].valid && !blocked[i];
			in_order = can_issue[i];  // a lane never passes an older one.
			if (can_issue[i])
				issue_num = issue_num + 1'b1;
			if (fetch_entry[i].valid && !can_issue[i])
				stall_req = 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/decode_and_issue.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module decode_and_issue(
	input  cpu_pkg::fetch_entry_t     [`ISSUE_NUM-1:0] fetch_entry,
	bypass_if.consumer                                 bypass,
	output cpu_pkg::pipeline_decode_t [`ISSUE_NUM-1:0] pipeline_decode,
	output logic [$clog2(`ISSUE_NUM+1)-1:0]            issue_num,
	output logic                                       stall_req
);
	import cpu_pkg::*;

	decoded_instr_t [`ISSUE_NUM-1:0]                      id_decoded;
	decoded_instr_t [`ISSUE_NUM-1:0]                      ex_decoded;
	decoded_instr_t [`MUL_PIPE_DEPTH-1:0][`ISSUE_NUM-1:0] stage_decoded;
	uint32_t        [`ISSUE_NUM*2-1:0]                    reg_forward;

	for (genvar i = 0; i < `ISSUE_NUM; i++) begin : gen_lane
		assign id_decoded[i] = fetch_entry[i].decoded;
		// bubbles are seen as NOPs by the hazard check.
		assign ex_decoded[i] = bypass.pipeline_exec[i].valid ?
			bypass.pipeline_exec[i].decoded : '0;
		for (genvar k = 0; k < `MUL_PIPE_DEPTH; k++) begin : gen_stage
			assign stage_decoded[k][i] = bypass.pipeline_stage[k][i].valid ?
				bypass.pipeline_stage[k][i].decoded : '0;
		end

		assign bypass.reg_raddr[i*2]   = id_decoded[i].rs1;
		assign bypass.reg_raddr[i*2+1] = id_decoded[i].rs2;

		register_forward i_fwd(
			.decoded_instr ( id_decoded[i]            ),
			.bypass        ( bypass                   ),
			.reg1_i        ( bypass.reg_rdata[i*2]    ),
			.reg2_i        ( bypass.reg_rdata[i*2+1]  ),
			.reg1_o        ( reg_forward[i*2]         ),
			.reg2_o        ( reg_forward[i*2+1]       )
		);
	end

	instr_issue i_issue(
		.fetch_entry   ( fetch_entry   ),
		.id_decoded    ( id_decoded    ),
		.ex_decoded    ( ex_decoded    ),
		.stage_decoded ( stage_decoded ),
		.issue_num     ( issue_num     ),
		.stall_req     ( stall_req     )
	);

	for (genvar i = 0; i < `ISSUE_NUM; i++) begin : gen_issue
		assign pipeline_decode[i].valid   = (i < issue_num);
		assign pipeline_decode[i].decoded = id_decoded[i];
		assign pipeline_decode[i].reg1    = reg_forward[i*2];
		assign pipeline_decode[i].reg2    = reg_forward[i*2+1];
	end

endmodule

`default_nettype wire

// ==== hdl/exec_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module exec_pipe(
	input  logic                                       clk,
	input  logic                                       rst_n,
	input  cpu_pkg::pipeline_decode_t [`ISSUE_NUM-1:0] pipeline_decode,
	bypass_if.producer                                 bypass,
	output logic                      [`ISSUE_NUM-1:0] wb_valid,
	output cpu_pkg::reg_addr_t        [`ISSUE_NUM-1:0] wb_rd,
	output cpu_pkg::uint32_t          [`ISSUE_NUM-1:0] wb_data
);
	import cpu_pkg::*;

	uint32_t regs [`REG_NUM];
	// index 0 is EX, index k is multiply stage k.
	pipeline_exec_t  [`MUL_PIPE_DEPTH:0][`ISSUE_NUM-1:0]   train;
	uint32_t         [`MUL_PIPE_DEPTH-1:0][`ISSUE_NUM-1:0] mul_a;
	uint32_t         [`MUL_PIPE_DEPTH-1:0][`ISSUE_NUM-1:0] mul_b;
	pipeline_memwb_t [`ISSUE_NUM-1:0]                      wb_q;
	uint32_t         [`ISSUE_NUM-1:0]                      opnd_b;
	logic                                                  mul_fwd;

	function automatic uint32_t alu(alu_op_e op, uint32_t a, uint32_t b);
		case (op)
			OP_ADD:  return a + b;
			OP_SUB:  return a - b;
			OP_AND:  return a & b;
			OP_OR:   return a | b;
			OP_XOR:  return a ^ b;
			default: return '0;  // MUL gets its result at the end of the train.
		endcase
	endfunction

	always_ff @(posedge clk) begin
		for (int i = 0; i < `ISSUE_NUM; i++) begin
			train[0][i].valid   <= pipeline_decode[i].valid;
			train[0][i].decoded <= pipeline_decode[i].decoded;
			train[0][i].result  <= alu(pipeline_decode[i].decoded.op, pipeline_decode[i].reg1,
				opnd_b[i]);
			mul_a[0][i] <= pipeline_decode[i].reg1;
			mul_b[0][i] <= opnd_b[i];
			for (int k = 1; k < `MUL_PIPE_DEPTH; k++) begin
				train[k][i] <= train[k-1][i];
				mul_a[k][i] <= mul_a[k-1][i];
				mul_b[k][i] <= mul_b[k-1][i];
			end
			train[`MUL_PIPE_DEPTH][i].valid   <= train[`MUL_PIPE_DEPTH-1][i].valid;
			train[`MUL_PIPE_DEPTH][i].decoded <= train[`MUL_PIPE_DEPTH-1][i].decoded;
			train[`MUL_PIPE_DEPTH][i].result  <= train[`MUL_PIPE_DEPTH-1][i].decoded.is_mul ?
				mul_a[`MUL_PIPE_DEPTH-1][i] * mul_b[`MUL_PIPE_DEPTH-1][i] :
				train[`MUL_PIPE_DEPTH-1][i].result;
			wb_q[i].valid <= train[`MUL_PIPE_DEPTH][i].valid &&
				train[`MUL_PIPE_DEPTH][i].decoded.rd != '0;
			wb_q[i].rd    <= train[`MUL_PIPE_DEPTH][i].decoded.rd;
			wb_q[i].wdata <= train[`MUL_PIPE_DEPTH][i].result;
		end
		if (!rst_n) begin
			for (int i = 0; i < `ISSUE_NUM; i++) begin
				for (int k = 0; k <= `MUL_PIPE_DEPTH; k++)
					train[k][i].valid <= 1'b0;
				wb_q[i].valid <= 1'b0;
			end
		end
	end

	// lane 1 is written last, so it wins a write to the same register.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int r = 0; r < `REG_NUM; r++)
				regs[r] <= '0;
		end else begin
			for (int i = 0; i < `ISSUE_NUM; i++)
				if (wb_q[i].valid)
					regs[wb_q[i].rd] <= wb_q[i].wdata;
		end
	end

	for (genvar i = 0; i < `ISSUE_NUM; i++) begin : gen_lane
		assign opnd_b[i] = pipeline_decode[i].decoded.uses_imm ?
			pipeline_decode[i].decoded.imm : pipeline_decode[i].reg2;
		assign bypass.pipeline_exec[i] = train[0][i];
		for (genvar k = 0; k < `MUL_PIPE_DEPTH; k++) begin : gen_stage
			assign bypass.pipeline_stage[k][i] = train[k+1][i];
		end
		assign bypass.pipeline_wb[i] = wb_q[i];
		assign wb_valid[i] = wb_q[i].valid;
		assign wb_rd[i]    = wb_q[i].rd;
		assign wb_data[i]  = wb_q[i].wdata;
	end

	for (genvar r = 0; r < `ISSUE_NUM*2; r++) begin : gen_read
		assign bypass.reg_rdata[r] = regs[bypass.reg_raddr[r]];
	end

	// an issued instruction never reads a MUL that has not reached WB.
	always_comb begin
		mul_fwd = 1'b0;
		for (int c = 0; c < `ISSUE_NUM; c++)
			for (int k = 0; k <= `MUL_PIPE_DEPTH; k++)
				for (int l = 0; l < `ISSUE_NUM; l++)
					if (pipeline_decode[c].valid && train[k][l].valid &&
						train[k][l].decoded.is_mul && train[k][l].decoded.rd != '0 &&
						(pipeline_decode[c].decoded.rs1 == train[k][l].decoded.rd ||
						pipeline_decode[c].decoded.rs2 == train[k][l].decoded.rd))
						mul_fwd = 1'b1;
	end

	a_mul_not_early: assert property (@(posedge clk) disable iff (!rst_n) !mul_fwd);

endmodule

`default_nettype wire

// ==== hdl/cpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module cpu_core(
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                instr_valid,
	input  cpu_pkg::uint32_t                    instr,
	output logic [$clog2(`ISSUE_NUM+1)-1:0]     credit_return,
	output logic                 [`ISSUE_NUM-1:0] wb_valid,
	output cpu_pkg::reg_addr_t   [`ISSUE_NUM-1:0] wb_rd,
	output cpu_pkg::uint32_t     [`ISSUE_NUM-1:0] wb_data
);
	import cpu_pkg::*;

	fetch_entry_t     [`ISSUE_NUM-1:0]        fetch_entry;
	pipeline_decode_t [`ISSUE_NUM-1:0]        pipeline_decode;
	logic             [$clog2(`ISSUE_NUM+1)-1:0] issue_num;

	bypass_if bypass();

	fetch_queue i_queue(
		.clk           ( clk           ),
		.rst_n         ( rst_n         ),
		.instr_valid   ( instr_valid   ),
		.instr         ( instr         ),
		.fetch_entry   ( fetch_entry   ),
		.issue_num     ( issue_num     ),
		.credit_return ( credit_return )
	);

	decode_and_issue i_issue(
		.fetch_entry     ( fetch_entry     ),
		.bypass          ( bypass          ),
		.pipeline_decode ( pipeline_decode ),
		.issue_num       ( issue_num       ),
		.stall_req       (                 )
	);

	exec_pipe i_exec(
		.clk             ( clk             ),
		.rst_n           ( rst_n           ),
		.pipeline_decode ( pipeline_decode ),
		.bypass          ( bypass          ),
		.wb_valid        ( wb_valid        ),
		.wb_rd           ( wb_rd           ),
		.wb_data         ( wb_data         )
	);

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD = 100
)(
	output logic clk
);

	initial clk = 1'b0;

	always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

// ==== testbench/tb_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module tb_cpu;
	import cpu_pkg::*;

	localparam int          NUM_WORDS       = 400;
	localparam int          WATCHDOG_CYCLES = NUM_WORDS * 20 + 200;
	localparam logic [31:0] SEED            = 32'h2558_71b9;

	logic                                clk;
	logic                                rst_n;
	logic                                instr_valid;
	uint32_t                             instr;
	logic [$clog2(`ISSUE_NUM+1)-1:0]     credit_return;
	logic                [`ISSUE_NUM-1:0] wb_valid;
	reg_addr_t           [`ISSUE_NUM-1:0] wb_rd;
	uint32_t             [`ISSUE_NUM-1:0] wb_data;

	logic [31:0] lfsr_state;
	uint32_t     model_regs [`REG_NUM];
	reg_addr_t   exp_rd [$];   // write-backs still owed, oldest first.
	uint32_t     exp_val [$];
	int          credits;
	int          sent;
	int          returned;
	int          value_errors;
	int          other_errors;

	tb_clock #(.PERIOD(100)) i_clock(.clk(clk));

	cpu_core i_dut(
		.clk           ( clk           ),
		.rst_n         ( rst_n         ),
		.instr_valid   ( instr_valid   ),
		.instr         ( instr         ),
		.credit_return ( credit_return ),
		.wb_valid      ( wb_valid      ),
		.wb_rd         ( wb_rd         ),
		.wb_data       ( wb_data       )
	);

	// galois form of x^32 + x^22 + x^2 + x + 1, shifting right.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			bits = {bits[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return bits;
	endfunction

	// registers come from r0 to r7 so that hazards are dense.
	function automatic logic [31:0] random_word();
		logic [2:0]  sel;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [4:0]  rd;
		logic [15:0] imm;
		logic [5:0]  funct;
		sel = 3'(take_bits(3));
		rs1 = 5'(take_bits(3));
		rs2 = 5'(take_bits(3));
		rd  = 5'(take_bits(3));
		if (sel == 3'd6)
			return {OPC_ADDI, rs1, rd, 16'(take_bits(16))};
		if (sel == 3'd7)
			return {OPC_ORI, rs1, rd, 16'(take_bits(16))};
		case (sel)
			3'd0:    funct = FUNCT_ADD;
			3'd1:    funct = FUNCT_SUB;
			3'd2:    funct = FUNCT_AND;
			3'd3:    funct = FUNCT_OR;
			3'd4:    funct = FUNCT_XOR;
			default: funct = FUNCT_MUL;
		endcase
		imm = 16'h0000;
		return {OPC_SPECIAL, rs1, rs2, rd, imm[4:0], funct};
	endfunction

	task automatic model_execute(input logic [31:0] word);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] result;
		logic [4:0]  rd;
		logic        writes;
		a      = model_regs[word[25:21]];
		b      = model_regs[word[20:16]];
		rd     = word[20:16];
		result = '0;
		writes = 1'b1;
		if (word[31:26] == OPC_SPECIAL) begin
			rd = word[15:11];
			case (word[5:0])
				FUNCT_ADD: result = a + b;
				FUNCT_SUB: result = a - b;
				FUNCT_AND: result = a & b;
				FUNCT_OR:  result = a | b;
				FUNCT_XOR: result = a ^ b;
				FUNCT_MUL: result = a * b;
				default:   writes = 1'b0;
			endcase
		end else if (word[31:26] == OPC_ADDI) begin
			result = a + {{16{word[15]}}, word[15:0]};
		end else if (word[31:26] == OPC_ORI) begin
			result = a | {16'h0000, word[15:0]};
		end else begin
			writes = 1'b0;
		end
		if (writes && rd != 5'd0) begin  // r0 is never written, so it keeps reading zero.
			model_regs[rd] = result;
			exp_rd.push_back(rd);
			exp_val.push_back(result);
		end
	endtask

	task automatic compare_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			value_errors++;
			$display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic print_counts();
		$display("errors: %0d wrong values, %0d other failures; %0d words sent, %0d credits back",
			value_errors, other_errors, sent, returned);
	endtask

	// called 1 ns after the rising edge, when credit_return holds this cycle's value.
	task automatic drive_cycle();
		logic [31:0] coin;
		logic [31:0] word;
		credits  += int'(credit_return);
		returned += int'(credit_return);
		if (credits > `FETCH_QUEUE_DEPTH) begin
			other_errors++;
			$display("the sender holds %0d credits at %0t ns, more than the queue has entries",
				credits, $time);
		end
		coin = take_bits(2);
		if (sent < NUM_WORDS && credits > 0 && coin != 32'd0) begin
			word = random_word();
			instr_valid = 1'b1;
			instr       = word;
			credits--;
			sent++;
			model_execute(word);
		end else begin
			instr_valid = 1'b0;
			instr       = '0;
		end
	endtask

	task automatic check_writeback(input int lane);
		reg_addr_t rd;
		uint32_t   val;
		if (wb_valid[lane]) begin
			if (exp_rd.size() == 0) begin
				other_errors++;
				$display("lane %0d wrote r%0d at %0t ns, but no instruction was left to retire",
					lane, wb_rd[lane], $time);
			end else begin
				rd  = exp_rd.pop_front();
				val = exp_val.pop_front();
				compare_value($sformatf("lane %0d wb_rd", lane), 32'(wb_rd[lane]), 32'(rd));
				compare_value($sformatf("lane %0d wb_data of r%0d", lane, rd), wb_data[lane], val);
			end
		end
	endtask

	// lane 0 is older than lane 1 in the same cycle.
	always @(negedge clk) begin
		if (rst_n) begin
			for (int i = 0; i < `ISSUE_NUM; i++)
				check_writeback(i);
		end
	end

	initial begin
		rst_n        = 1'b0;
		instr_valid  = 1'b0;
		instr        = '0;
		lfsr_state   = SEED;
		credits      = `FETCH_QUEUE_DEPTH;
		sent         = 0;
		returned     = 0;
		value_errors = 0;
		other_errors = 0;
		for (int r = 0; r < `REG_NUM; r++)
			model_regs[r] = '0;
		repeat (3) @(posedge clk);
		#1 rst_n = 1'b1;

		// nothing may come out of an idle core.
		repeat (4) begin
			@(posedge clk);
			#1;
			compare_value("credit_return while idle", 32'(credit_return), 32'd0);
			compare_value("wb_valid while idle", 32'(wb_valid), 32'd0);
		end

		while (sent < NUM_WORDS || returned != sent) begin
			@(posedge clk);
			#1;
			drive_cycle();
		end
		repeat (8) begin  // the last issued words reach WB within these cycles.
			@(posedge clk);
			#1;
			drive_cycle();
		end

		compare_value("credits returned against words sent", returned, sent);
		compare_value("credits held after the drain", credits, `FETCH_QUEUE_DEPTH);
		compare_value("write-backs still expected", exp_rd.size(), 0);
		print_counts();
		if (value_errors == 0 && other_errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: the core did not retire all %0d words within %0d cycles",
			NUM_WORDS, WATCHDOG_CYCLES);
		print_counts();
		$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
hdl/cpu_pkg.sv
hdl/bypass_if.sv
hdl/instr_decoder.sv
hdl/fetch_queue.sv
hdl/register_forward.sv
hdl/instr_issue.sv
hdl/decode_and_issue.sv
hdl/exec_pipe.sv
hdl/cpu_core.sv
testbench/tb_clock.sv
testbench/tb_cpu.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_cpu -f tb.f -o tb_cpu_sim \
	> build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_cpu_sim > sim.log 2>&1
grep -q '\*\* FAIL \*\*' sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q '\*\* PASS \*\*' sim.log || { echo "simulation ended without a result, see sim.log"; exit 1; }
echo "simulation passed"
exit 0
